// ==== design/i2c_pkg.sv ====
package i2c_pkg;

  localparam int n_bus   = 2;                                  // Independent I2C buses
  localparam int bus_w   = (n_bus > 1) ? $clog2(n_bus) : 1;    // Bus index width
  localparam int clk_div = 4;                                  // Clocks per quarter SCL period
  localparam int div_w   = (clk_div > 1) ? $clog2(clk_div) : 1;

  // One host request
  typedef struct packed {
    logic [bus_w-1:0] bus;
    logic [6:0]       addr;
    logic             rw;          // 0 write, 1 read
    logic             two_bytes;
    logic [15:0]      data;        // MSB byte goes out first
  } i2c_cmd_t;

  // One finished transfer
  typedef struct packed {
    logic [bus_w-1:0] bus;
    logic             got_ack;     // Address acknowledged
    logic             rw;
    logic [15:0]      read_data;
  } i2c_rsp_t;

  typedef enum logic [3:0] {
    st_idle,
    st_start,
    st_addr,
    st_rw_bit,
    st_slave_ack,
    st_write_byte,
    st_read_byte,
    st_master_ack,
    st_stop1,
    st_stop2
  } i2c_state_t;

endpackage

// ==== design/i2c_cmd_dispatch.sv ====
`timescale 1ns/1ps

module i2c_cmd_dispatch (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cmd_start,
  input  i2c_pkg::i2c_cmd_t         cmd,
  input  logic [i2c_pkg::n_bus-1:0] bus_ready,
  input  logic [i2c_pkg::n_bus-1:0] slot_free,
  output logic [i2c_pkg::n_bus-1:0] cmd_ready,
  output logic [i2c_pkg::n_bus-1:0] bus_start,
  output i2c_pkg::i2c_cmd_t         bus_cmd [i2c_pkg::n_bus]
);
  import i2c_pkg::*;

  logic [n_bus-1:0] hit;

  // A start already on its way to the master blocks the bus too
  assign cmd_ready = bus_ready & slot_free & ~bus_start;

  always_comb
  begin
    for (int i = 0; i < n_bus; i++)
    begin
      hit[i] = cmd_start && (cmd.bus == bus_w'(i)) && cmd_ready[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bus_start <= '0;
    end
    else
    begin
      bus_start <= hit;              // One-cycle pulse to the addressed bus only
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < n_bus; i++)
    begin
      if (hit[i])
      begin
        bus_cmd[i] <= cmd;
      end
    end
  end

  for (genvar g = 0; g < n_bus; g++)
  begin : g_chk
    // Master must still be idle when its start arrives
    a_start_ready : assert property (@(posedge clk) disable iff (rst)
      bus_start[g] |-> bus_ready[g]);
  end

endmodule

// ==== design/i2c_master.sv ====
`timescale 1ns/1ps

module i2c_master (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  i2c_pkg::i2c_cmd_t cmd,
  input  logic              sda_in,
  input  logic              scl_in,
  output logic              ready,
  output logic              sda_oe,
  output logic              scl_oe,
  output logic              done,
  output i2c_pkg::i2c_rsp_t rsp
);
  import i2c_pkg::*;

  i2c_state_t       state;
  i2c_cmd_t         cmd_q;
  logic [div_w-1:0] div_cnt;
  logic [1:0]       qtr;
  logic [3:0]       bit_cnt;
  logic [15:0]      rdata;
  logic             got_ack;
  logic             ack_q;
  logic             in_data;
  logic             tick;
  logic             sda_upd;
  logic             sample;
  logic             bit_end;
  logic             clocked;
  logic             accept;

  // Quarters 0,1 SCL low, quarters 2,3 SCL high
  assign tick    = (div_cnt == div_w'(clk_div - 1));
  assign sda_upd = tick && (qtr == 2'd0);      // SDA moves mid SCL low
  assign sample  = tick && (qtr == 2'd2);      // Mid SCL high
  assign bit_end = tick && (qtr == 2'd3);

  assign clocked = state inside {st_addr, st_rw_bit, st_slave_ack, st_write_byte,
                                 st_read_byte, st_master_ack, st_stop1};
  assign scl_oe  = clocked && !qtr[1];
  assign ready   = (state == st_idle) && !done && sda_in && scl_in;
  assign accept  = (state == st_idle) && start && ready;
  assign rsp     = '{bus: cmd_q.bus, got_ack: got_ack, rw: cmd_q.rw, read_data: rdata};

  always_ff @(posedge clk)
  begin
    if (rst || state == st_idle)
    begin
      div_cnt <= '0;
      qtr     <= '0;
    end
    else if (tick)
    begin
      div_cnt <= '0;
      qtr     <= qtr + 2'd1;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= st_idle;
      bit_cnt <= '0;
      in_data <= 1'b0;
      sda_oe  <= 1'b0;
      done    <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        st_idle:
        begin
          in_data <= 1'b0;
          if (accept)
            state <= st_start;
        end
        st_start:
        begin
          if (tick && qtr == 2'd1)
            sda_oe <= 1'b1;                    // Start: SDA falls, SCL high
          if (bit_end)
          begin
            state   <= st_addr;
            bit_cnt <= 4'd6;
          end
        end
        st_addr:
        begin
          if (sda_upd)
            sda_oe <= ~cmd_q.addr[bit_cnt[2:0]];
          if (bit_end)
          begin
            if (bit_cnt == 4'd0)
              state <= st_rw_bit;
            else
              bit_cnt <= bit_cnt - 4'd1;
          end
        end
        st_rw_bit:
        begin
          if (sda_upd)
            sda_oe <= ~cmd_q.rw;
          if (bit_end)
            state <= st_slave_ack;
        end
        st_slave_ack:
        begin
          if (sda_upd)
            sda_oe <= 1'b0;                    // Let the slave drive
          if (bit_end)
          begin
            if (!in_data)
            begin
              in_data <= 1'b1;
              bit_cnt <= cmd_q.two_bytes ? 4'd15 : 4'd7;
              if (!ack_q)
                state <= st_stop1;             // Address NACK ends early
              else if (cmd_q.rw)
                state <= st_read_byte;
              else
                state <= st_write_byte;
            end
            else if (ack_q && bit_cnt == 4'd8)
            begin
              state   <= st_write_byte;
              bit_cnt <= 4'd7;
            end
            else
            begin
              state <= st_stop1;
            end
          end
        end
        st_write_byte:
        begin
          if (sda_upd)
            sda_oe <= ~cmd_q.data[bit_cnt];
          if (bit_end)
          begin
            if (bit_cnt[2:0] == 3'd0)
              state <= st_slave_ack;
            else
              bit_cnt <= bit_cnt - 4'd1;
          end
        end
        st_read_byte:
        begin
          if (sda_upd)
            sda_oe <= 1'b0;
          if (bit_end)
          begin
            if (bit_cnt[2:0] == 3'd0)
              state <= st_master_ack;
            else
              bit_cnt <= bit_cnt - 4'd1;
          end
        end
        st_master_ack:
        begin
          if (sda_upd)
            sda_oe <= (bit_cnt == 4'd8);       // ACK only if a byte follows
          if (bit_end)
          begin
            if (bit_cnt == 4'd8)
            begin
              state   <= st_read_byte;
              bit_cnt <= 4'd7;
            end
            else
            begin
              state <= st_stop1;
            end
          end
        end
        st_stop1:
        begin
          if (sda_upd)
            sda_oe <= 1'b1;                    // Hold SDA low for stop
          if (bit_end)
            state <= st_stop2;
        end
        st_stop2:
        begin
          if (tick && qtr == 2'd1)
            sda_oe <= 1'b0;                    // Stop: SDA rises, SCL high
          if (bit_end)
          begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd;
      rdata <= '0;
    end
    if (sample)
    begin
      ack_q <= ~sda_in;
      if (state == st_slave_ack && !in_data)
        got_ack <= ~sda_in;
      if (state == st_read_byte)
        rdata[bit_cnt] <= sda_in;
    end
  end

  a_sda_stable : assert property (@(posedge clk) disable iff (rst)
    (sda_oe != $past(sda_oe)) && !(state inside {st_start, st_stop2}) |-> scl_oe);

  a_done_pulse : assert property (@(posedge clk) disable iff (rst)
    done |=> !done);

endmodule

// ==== design/i2c_result_collect.sv ====
`timescale 1ns/1ps

module i2c_result_collect (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [i2c_pkg::n_bus-1:0] done,
  input  i2c_pkg::i2c_rsp_t         bus_rsp [i2c_pkg::n_bus],
  output logic [i2c_pkg::n_bus-1:0] slot_free,
  output logic                      rsp_valid,
  output i2c_pkg::i2c_rsp_t         rsp
);
  import i2c_pkg::*;

  logic [n_bus-1:0] full;
  i2c_rsp_t         slot [n_bus];
  logic [bus_w-1:0] ptr;
  logic [bus_w-1:0] pick;
  logic             pick_ok;

  assign slot_free = ~full;

  // First full slot at or after the pointer
  always_comb
  begin
    int idx;
    pick_ok = 1'b0;
    pick    = ptr;
    for (int k = 0; k < n_bus; k++)
    begin
      idx = (int'(ptr) + k) % n_bus;
      if (!pick_ok && full[idx])
      begin
        pick_ok = 1'b1;
        pick    = bus_w'(idx);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full      <= '0;
      ptr       <= '0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= pick_ok;
      if (pick_ok)
      begin
        full[pick] <= 1'b0;
        ptr        <= bus_w'((int'(pick) + 1) % n_bus);   // Next bus gets priority
      end
      for (int i = 0; i < n_bus; i++)
      begin
        if (done[i])
          full[i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pick_ok)
      rsp <= slot[pick];
    for (int i = 0; i < n_bus; i++)
    begin
      if (done[i])
        slot[i] <= bus_rsp[i];
    end
  end

  for (genvar g = 0; g < n_bus; g++)
  begin : g_chk
    a_no_overwrite : assert property (@(posedge clk) disable iff (rst)
      done[g] |-> !full[g]);
  end

endmodule

// ==== design/i2c_multi_bus.sv ====
`timescale 1ns/1ps

module i2c_multi_bus (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cmd_start,
  input  i2c_pkg::i2c_cmd_t         cmd,
  input  logic [i2c_pkg::n_bus-1:0] sda_in,
  input  logic [i2c_pkg::n_bus-1:0] scl_in,
  output logic [i2c_pkg::n_bus-1:0] cmd_ready,
  output logic                      rsp_valid,
  output i2c_pkg::i2c_rsp_t         rsp,
  output logic [i2c_pkg::n_bus-1:0] sda_oe,
  output logic [i2c_pkg::n_bus-1:0] scl_oe
);
  import i2c_pkg::*;

  logic [n_bus-1:0] bus_ready;
  logic [n_bus-1:0] slot_free;
  logic [n_bus-1:0] bus_start;
  logic [n_bus-1:0] bus_done;
  i2c_cmd_t         bus_cmd [n_bus];
  i2c_rsp_t         bus_rsp [n_bus];

  i2c_cmd_dispatch u_i2c_cmd_dispatch (
    .clk       (clk),
    .rst       (rst),
    .cmd_start (cmd_start),
    .cmd       (cmd),
    .bus_ready (bus_ready),
    .slot_free (slot_free),
    .cmd_ready (cmd_ready),
    .bus_start (bus_start),
    .bus_cmd   (bus_cmd)
  );

  for (genvar g = 0; g < n_bus; g++)
  begin : g_bus
    i2c_master u_i2c_master (
      .clk    (clk),
      .rst    (rst),
      .start  (bus_start[g]),
      .cmd    (bus_cmd[g]),
      .sda_in (sda_in[g]),
      .scl_in (scl_in[g]),
      .ready  (bus_ready[g]),
      .sda_oe (sda_oe[g]),
      .scl_oe (scl_oe[g]),
      .done   (bus_done[g]),
      .rsp    (bus_rsp[g])
    );
  end

  i2c_result_collect u_i2c_result_collect (
    .clk       (clk),
    .rst       (rst),
    .done      (bus_done),
    .bus_rsp   (bus_rsp),
    .slot_free (slot_free),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

// ==== tb/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model #(
  parameter logic [6:0]  dev_addr = 7'h50,
  parameter logic [15:0] init_val = 16'h0000
) (
  input  logic scl,
  input  logic sda,
  input  logic wide,                           // Reads return both register bytes
  output logic sda_oe                          // High pulls SDA low
);

  logic [15:0] reg_val = init_val;
  logic [7:0]  sh;
  logic [7:0]  tx;
  logic [7:0]  rx [2];
  logic        pull = 1'b0;
  logic        busy = 1'b0;
  logic        matched = 1'b0;
  logic        rd = 1'b0;
  logic        sending = 1'b0;
  logic        m_ack = 1'b0;
  logic        scl_q = 1'b1;
  logic        sda_q = 1'b1;
  int          bit_idx;
  int          frame;
  int          rx_cnt;

  assign sda_oe = pull;

  always @(scl or sda)
  begin
    if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
    begin
      if (sda === 1'b0)
      begin
        busy    = 1'b1;                        // Start condition
        bit_idx = -1;                          // SCL falls once before the first bit
        frame   = 0;
        rx_cnt  = 0;
        matched = 1'b0;
        sending = 1'b0;
        pull    = 1'b0;
      end
      else if (busy)
      begin
        if (matched && !rd && rx_cnt == 2)
          reg_val = {rx[0], rx[1]};            // MSB byte arrives first
        else if (matched && !rd && rx_cnt == 1)
          reg_val[7:0] = rx[0];
        busy = 1'b0;                           // Stop condition
        pull = 1'b0;
      end
    end
    else if (busy && scl === 1'b1 && scl_q !== 1'b1)
    begin
      if (bit_idx < 8)
        sh = {sh[6:0], sda};
      else
        m_ack = !sda;
    end
    else if (busy && scl === 1'b0 && scl_q === 1'b1)
    begin
      if (bit_idx < 7)
      begin
        bit_idx++;
        pull = sending && !tx[7 - bit_idx];
      end
      else if (bit_idx == 7)
      begin
        bit_idx = 8;
        if (frame == 0)
        begin
          matched = (sh[7:1] == dev_addr);
          rd      = sh[0];
          pull    = matched;                   // Address ACK
        end
        else
        begin
          if (matched && !rd && frame <= 2)
          begin
            rx[frame - 1] = sh;
            rx_cnt++;
          end
          pull = matched && !rd;               // Master owns the ACK on reads
        end
      end
      else
      begin
        bit_idx = 0;
        frame++;
        sending = matched && rd && (frame == 1 || m_ack);
        tx      = (frame == 1 && wide) ? reg_val[15:8] : reg_val[7:0];
        pull    = sending && !tx[7];
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule

// ==== tb/tb_i2c_multi_bus.sv ====
`timescale 1ns/1ps

module tb_i2c_multi_bus;
  import i2c_pkg::*;

  localparam int          xfer_clks = 30 * 4 * clk_div;   // Two-byte transfer in clocks
  localparam logic [6:0]  base_addr = 7'h50;
  localparam logic [15:0] init0     = 16'hA55A;
  localparam logic [15:0] init1     = 16'h3CC3;

  logic             clk;
  logic             rst;
  logic             cmd_start;
  i2c_cmd_t         cmd;
  logic [n_bus-1:0] sda_in;
  logic [n_bus-1:0] scl_in;
  logic [n_bus-1:0] sda_oe;
  logic [n_bus-1:0] scl_oe;
  logic [n_bus-1:0] slv_oe;
  logic [n_bus-1:0] cmd_ready;
  logic [n_bus-1:0] wide;
  logic [n_bus-1:0] pending;
  logic             rsp_valid;
  i2c_rsp_t         rsp;
  i2c_rsp_t         exp_rsp [n_bus];
  logic [15:0]      exp_reg [n_bus];
  int               issued [n_bus];
  int               received [n_bus];
  int               err_cnt;
  int               err_mark;
  int               test_cnt;
  int               test_fail;
  logic [31:0]      lcg_state;
  logic [15:0]      d0;
  logic [15:0]      d1;

  i2c_multi_bus u_i2c_multi_bus (
    .clk       (clk),
    .rst       (rst),
    .cmd_start (cmd_start),
    .cmd       (cmd),
    .sda_in    (sda_in),
    .scl_in    (scl_in),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .sda_oe    (sda_oe),
    .scl_oe    (scl_oe)
  );

  i2c_slave_model #(.dev_addr(base_addr), .init_val(init0)) u_slave0 (
    .scl    (scl_in[0]),
    .sda    (sda_in[0]),
    .wide   (wide[0]),
    .sda_oe (slv_oe[0])
  );

  i2c_slave_model #(.dev_addr(base_addr + 7'd1), .init_val(init1)) u_slave1 (
    .scl    (scl_in[1]),
    .sda    (sda_in[1]),
    .wide   (wide[1]),
    .sda_oe (slv_oe[1])
  );

  for (genvar b = 0; b < n_bus; b++)
  begin : g_line
    // Wired-AND, an undriven enable counts as released
    assign sda_in[b]  = (sda_oe[b] !== 1'b1) && (slv_oe[b] !== 1'b1);
    assign scl_in[b]  = (scl_oe[b] !== 1'b1);
    assign pending[b] = (issued[b] != received[b]);

    a_idle_quiet : assert property (@(posedge clk) disable iff (rst)
      (sda_oe[b] || scl_oe[b]) |-> pending[b])
    else
    begin
      $display("bus %0d drove its lines with no transfer issued at %0t", b, $time);
      err_cnt++;
    end
  end

  a_rsp_expected : assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> pending[rsp.bus])
  else
  begin
    $display("result for bus %0d arrived with none outstanding at %0t", $sampled(rsp.bus),
             $time);
    err_cnt++;
  end

  a_rsp_match : assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> rsp == exp_rsp[rsp.bus])
  else
  begin
    $display("[FAIL] %0t bus %0d result %h, expected %h", $time, $sampled(rsp.bus),
             $sampled(rsp), exp_rsp[$sampled(rsp.bus)]);
    err_cnt++;
  end

  a_rsp_release : assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> !sda_oe[rsp.bus] && !scl_oe[rsp.bus] && cmd_ready[rsp.bus])
  else
  begin
    $display("[FAIL] %0t bus %0d not released and ready at its result", $time,
             $sampled(rsp.bus));
    err_cnt++;
  end

  always @(posedge clk)
  begin
    if (!rst && rsp_valid)
      received[rsp.bus] <= received[rsp.bus] + 1;
  end

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    #(20 * xfer_clks * 4);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  task automatic check_cond(input logic ok, input string what);
    assert (ok)
    else
    begin
      $display("[FAIL] %0t %s", $time, what);
      err_cnt++;
    end
  endtask

  // Waits for the bus, records the expected result, pulses cmd_start
  task automatic send_cmd(input int b, input logic [6:0] addr, input logic rw,
                          input logic two, input logic [15:0] data);
    int          waited;
    logic        hit;
    logic [15:0] rdata;
    waited = 0;
    while (!(cmd_ready[b] && !pending[b]) && waited < 2 * xfer_clks)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!cmd_ready[b])
    begin
      $display("bus %0d never became ready for a command", b);
      err_cnt++;
    end
    hit   = (addr == base_addr + 7'(b));
    rdata = 16'h0000;
    if (hit && rw)
      rdata = two ? exp_reg[b] : {8'h00, exp_reg[b][7:0]};
    if (hit && !rw)
      exp_reg[b] = two ? data : {exp_reg[b][15:8], data[7:0]};
    exp_rsp[b] = '{bus: bus_w'(b), got_ack: hit, rw: rw, read_data: rdata};
    wide[b]    = two;
    issued[b]  = issued[b] + 1;
    cmd        = '{bus: bus_w'(b), addr: addr, rw: rw, two_bytes: two, data: data};
    cmd_start  = 1'b1;
    @(posedge clk);
    #1;
    cmd_start  = 1'b0;
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (pending != '0 && waited < 2 * xfer_clks)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pending != '0)
    begin
      $display("no result arrived for buses %b", pending);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == err_mark)
    begin
      $display("test %0d %s: ok", test_cnt, name);
    end
    else
    begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial
  begin
    lcg_state  = 32'd45044;
    rst        = 1'b1;
    cmd_start  = 1'b0;
    cmd        = '0;
    wide       = '0;
    issued     = '{default: 0};
    received   = '{default: 0};
    exp_reg[0] = init0;
    exp_reg[1] = init1;
    err_cnt    = 0;
    err_mark   = 0;
    test_cnt   = 0;
    test_fail  = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    repeat (2) @(posedge clk);
    #1;
    check_cond(cmd_ready == '1 && sda_oe == '0 && scl_oe == '0, "bus state after reset");
    end_test("reset state");

    d0 = next_rand();
    send_cmd(0, base_addr, 1'b0, 1'b1, d0);
    wait_results();
    send_cmd(0, base_addr, 1'b1, 1'b1, 16'h0000);
    wait_results();
    end_test("two-byte write and read");

    d0 = next_rand();
    send_cmd(0, base_addr, 1'b0, 1'b0, d0);
    wait_results();
    send_cmd(0, base_addr, 1'b1, 1'b0, 16'h0000);
    wait_results();
    send_cmd(0, base_addr, 1'b1, 1'b1, 16'h0000);     // High byte must be untouched
    wait_results();
    end_test("one-byte write and read");

    send_cmd(1, 7'h2A, 1'b0, 1'b1, next_rand());
    wait_results();
    send_cmd(1, base_addr + 7'd1, 1'b1, 1'b1, 16'h0000);
    wait_results();
    end_test("address nack");

    d0 = next_rand();
    d1 = next_rand();
    send_cmd(0, base_addr, 1'b0, 1'b1, d0);
    send_cmd(1, base_addr + 7'd1, 1'b0, 1'b1, d1);  // Next cycle, other bus
    wait_results();
    send_cmd(0, base_addr, 1'b1, 1'b1, 16'h0000);
    send_cmd(1, base_addr + 7'd1, 1'b1, 1'b1, 16'h0000);
    wait_results();
    end_test("both buses in flight");

    send_cmd(0, base_addr, 1'b1, 1'b1, 16'h0000);
    repeat (4) @(posedge clk);
    #1;
    check_cond(!cmd_ready[0], "bus 0 ready during a transfer");
    cmd       = '{bus: '0, addr: base_addr, rw: 1'b0, two_bytes: 1'b1, data: ~exp_reg[0]};
    cmd_start = 1'b1;
    @(posedge clk);
    #1;
    cmd_start = 1'b0;
    wait_results();
    repeat (8 * 4 * clk_div) @(posedge clk);          // Any extra transfer shows up here
    #1;
    check_cond(cmd_ready[0], "bus 0 ready after the transfer");
    end_test("start while busy");

    $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/i2c_pkg.sv
design/i2c_cmd_dispatch.sv
design/i2c_master.sv
design/i2c_result_collect.sv
design/i2c_multi_bus.sv
tb/i2c_slave_model.sv
tb/tb_i2c_multi_bus.sv
